// File: am_lock_top.f
logic/am_code_pkg.sv
logic/am_lock_pkg.sv
logic/am_matcher.sv
logic/am_period_counter.sv
logic/am_lock_fsm.sv
logic/am_lock_top.sv
sim/tb_am_lock_top.sv

// File: logic/am_code_pkg.sv
`default_nettype none

package am_code_pkg;

        localparam int NB_CODED_BLOCK = 66;
        localparam int NB_LANE_ID     = 5;
        localparam int N_ALIGNER      = 20;
        localparam int NB_AM_CODE     = 24;                     // M0..M2 or M4..M6

        localparam logic [1:0] SYNC_CTRL = 2'b10;

        typedef struct packed {
                logic [1:0]            sync_hdr;
                logic [NB_AM_CODE-1:0] m_low;                   // M0, M1, M2
                logic [7:0]            bip3;
                logic [NB_AM_CODE-1:0] m_high;                  // M4, M5, M6
                logic [7:0]            bip7;
        } coded_block_t;

        // M0..M2 per lane where M4..M6 carry the bitwise inverse
        localparam logic [NB_AM_CODE-1:0] am_lane_code [N_ALIGNER] = '{
                24'hC1_68_21,
                24'h9D_71_8E,
                24'h59_4B_E8,
                24'h4D_95_7B,
                24'hF5_07_09,                                   // Lane 4
                24'hDD_14_C2,
                24'h9A_4A_26,
                24'h7B_45_66,
                24'hA0_24_76,
                24'h68_C9_FB,
                24'hFD_6C_99,
                24'hB9_91_55,
                24'h5C_B9_B2,
                24'h1A_F8_BD,
                24'h83_C7_CA,
                24'h35_36_CD,
                24'hC4_31_4C,
                24'hAD_D6_B7,
                24'h5F_66_2A,
                24'hC0_F0_E5                                    // Lane 19
        };

endpackage

`default_nettype wire

// File: logic/am_lock_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module am_lock_fsm
#(
        parameter  int MAX_VAL_AM       = 20,
        parameter  int MAX_INV_AM       = 8,
        parameter  int NB_ERROR_COUNTER = 64,
        localparam int NB_VAL_AM        = $clog2(MAX_VAL_AM + 1),
        localparam int NB_INV_AM        = $clog2(MAX_INV_AM + 1)
)
(
        input  wire                                i_clock,
        input  wire                                i_rst_n,
        input  wire                                i_rf_enable,
        input  wire                                i_block_lock,
        input  wire [NB_VAL_AM-1:0]                i_rf_valid_am_thr,
        input  wire [NB_INV_AM-1:0]                i_rf_invalid_am_thr,
        input  wire am_lock_pkg::am_match_t        i_match,
        input  wire am_lock_pkg::period_t          i_period,
        output logic                               o_restart,
        output am_code_pkg::coded_block_t          o_data,
        output logic                               o_valid,
        output logic [am_code_pkg::NB_LANE_ID-1:0] o_lane_id,
        output logic                               o_am_lock,
        output logic                               o_resync,
        output logic                               o_start_of_lane,
        output logic [NB_ERROR_COUNTER-1:0]        o_error_counter
);
        import am_code_pkg::*;
        import am_lock_pkg::*;

        lock_state_e                 state_q;
        lock_state_e                 state_d;
        logic [NB_LANE_ID-1:0]       lane_q;
        logic [NB_LANE_ID-1:0]       lane_d;
        logic [NB_VAL_AM-1:0]        val_cnt_q;
        logic [NB_VAL_AM-1:0]        val_cnt_d;
        logic [NB_INV_AM-1:0]        inv_cnt_q;
        logic [NB_INV_AM-1:0]        inv_cnt_d;
        logic [NB_ERROR_COUNTER-1:0] err_cnt_q;
        logic [NB_ERROR_COUNTER-1:0] err_cnt_d;
        logic                        resync_d;
        logic                        resync_q;
        logic                        sol_d;
        logic                        sol_q;
        logic                        valid_q;
        logic [NB_CODED_BLOCK-1:0]   data_q;
        logic                        enabled;
        logic                        same_lane_hit;

        assign enabled       = i_rf_enable && i_block_lock;
        assign same_lane_hit = i_match.hit && (i_match.lane_id == lane_q);
        assign o_restart     = enabled && (state_q == ST_HUNT) && i_match.hit;

        always_comb
        begin
                state_d   = state_q;
                lane_d    = lane_q;
                val_cnt_d = val_cnt_q;
                inv_cnt_d = inv_cnt_q;
                err_cnt_d = err_cnt_q;
                resync_d  = 1'b0;
                sol_d     = 1'b0;

                if (!enabled)
                begin
                        state_d   = ST_HUNT;                    // Forced drop without resync
                        val_cnt_d = '0;
                        inv_cnt_d = '0;
                end
                else
                begin
                        case (state_q)
                                ST_HUNT:
                                begin
                                        if (i_match.hit)
                                        begin
                                                lane_d    = i_match.lane_id;
                                                val_cnt_d = NB_VAL_AM'(1);
                                                inv_cnt_d = '0;
                                                if (i_rf_valid_am_thr <= NB_VAL_AM'(1))
                                                        state_d = ST_LOCKED;
                                                else
                                                        state_d = ST_CHECK;
                                        end
                                end
                                ST_CHECK:
                                begin
                                        if (i_period.expected && same_lane_hit)
                                        begin
                                                val_cnt_d = val_cnt_q + 1'b1;
                                                if (val_cnt_d >= i_rf_valid_am_thr)
                                                        state_d = ST_LOCKED;
                                        end
                                        else if (i_period.expected)
                                        begin
                                                val_cnt_d = '0;
                                                state_d   = ST_HUNT;
                                        end
                                end
                                ST_LOCKED:
                                begin
                                        if (i_period.expected && same_lane_hit)
                                        begin
                                                inv_cnt_d = '0;
                                                sol_d     = 1'b1;
                                        end
                                        else if (i_period.expected)
                                        begin
                                                inv_cnt_d = inv_cnt_q + 1'b1;
                                                err_cnt_d = err_cnt_q + 1'b1;
                                                if (inv_cnt_d >= i_rf_invalid_am_thr)
                                                begin
                                                        resync_d  = 1'b1;
                                                        state_d   = ST_HUNT;
                                                        val_cnt_d = '0;
                                                        inv_cnt_d = '0;
                                                end
                                        end
                                end
                                default:
                                begin
                                        state_d = ST_HUNT;
                                end
                        endcase
                end
        end

        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        state_q   <= ST_HUNT;
                        lane_q    <= '0;
                        val_cnt_q <= '0;
                        inv_cnt_q <= '0;
                        err_cnt_q <= '0;
                        resync_q  <= 1'b0;
                        sol_q     <= 1'b0;
                        valid_q   <= 1'b0;
                end
                else
                begin
                        state_q   <= state_d;
                        lane_q    <= lane_d;
                        val_cnt_q <= val_cnt_d;
                        inv_cnt_q <= inv_cnt_d;
                        err_cnt_q <= err_cnt_d;
                        resync_q  <= resync_d;
                        sol_q     <= sol_d;
                        valid_q   <= i_match.valid;
                end
        end

        always_ff @(posedge i_clock)
        begin
                data_q <= i_match.block;                        // Stage 2 of the pass-through
        end

        assign o_data          = coded_block_t'(data_q);
        assign o_valid         = valid_q;
        assign o_lane_id       = lane_q;
        assign o_am_lock       = (state_q == ST_LOCKED);
        assign o_resync        = resync_q;
        assign o_start_of_lane = sol_q;
        assign o_error_counter = err_cnt_q;

endmodule

`default_nettype wire

// File: logic/am_lock_pkg.sv
`default_nettype none

package am_lock_pkg;

        typedef enum logic [1:0] {
                ST_HUNT   = 2'd0,
                ST_CHECK  = 2'd1,
                ST_LOCKED = 2'd2
        } lock_state_e;

        // Stage-1 view of one block as seen by the matcher
        typedef struct packed {
                logic                               hit;
                logic [am_code_pkg::NB_LANE_ID-1:0] lane_id;
                logic                               valid;
                am_code_pkg::coded_block_t          block;
        } am_match_t;

        typedef struct packed {
                logic expected;                                 // Marker due on this block
        } period_t;

endpackage

`default_nettype wire

// File: logic/am_lock_top.sv
`timescale 1ns/10ps
`default_nettype none

module am_lock_top
#(
        parameter  int N_BLOCKS         = 16,
        parameter  int MAX_VAL_AM       = 20,
        parameter  int MAX_INV_AM       = 8,
        parameter  int NB_ERROR_COUNTER = 64,
        localparam int NB_VAL_AM        = $clog2(MAX_VAL_AM + 1),
        localparam int NB_INV_AM        = $clog2(MAX_INV_AM + 1)
)
(
        input  wire                                i_clock,
        input  wire                                i_rst_n,
        input  wire                                i_rf_enable,
        input  wire                                i_valid,
        input  wire                                i_block_lock,
        input  wire am_code_pkg::coded_block_t     i_data,
        input  wire [NB_VAL_AM-1:0]                i_rf_valid_am_thr,
        input  wire [NB_INV_AM-1:0]                i_rf_invalid_am_thr,
        output am_code_pkg::coded_block_t          o_data,
        output logic                               o_valid,
        output logic [am_code_pkg::NB_LANE_ID-1:0] o_lane_id,
        output logic [NB_ERROR_COUNTER-1:0]        o_error_counter,
        output logic                               o_am_lock,
        output logic                               o_resync,
        output logic                               o_start_of_lane
);
        import am_lock_pkg::*;

        am_match_t s1_match;
        period_t   s1_period;
        logic      restart;                                     // Hunt hit realigns the period

        am_matcher
        u_am_matcher
        (
                .i_clock        (i_clock),
                .i_rst_n        (i_rst_n),
                .i_data         (i_data),
                .i_valid        (i_valid),
                .o_match        (s1_match)
        );

        am_period_counter
        #(
                .N_BLOCKS       (N_BLOCKS)
        )
        u_am_period_counter
        (
                .i_clock        (i_clock),
                .i_rst_n        (i_rst_n),
                .i_valid        (i_valid),
                .i_restart      (restart),
                .o_period       (s1_period)
        );

        am_lock_fsm
        #(
                .MAX_VAL_AM             (MAX_VAL_AM),
                .MAX_INV_AM             (MAX_INV_AM),
                .NB_ERROR_COUNTER       (NB_ERROR_COUNTER)
        )
        u_am_lock_fsm
        (
                .i_clock                (i_clock),
                .i_rst_n                (i_rst_n),
                .i_rf_enable            (i_rf_enable),
                .i_block_lock           (i_block_lock),
                .i_rf_valid_am_thr      (i_rf_valid_am_thr),
                .i_rf_invalid_am_thr    (i_rf_invalid_am_thr),
                .i_match                (s1_match),
                .i_period               (s1_period),
                .o_restart              (restart),
                .o_data                 (o_data),
                .o_valid                (o_valid),
                .o_lane_id              (o_lane_id),
                .o_am_lock              (o_am_lock),
                .o_resync               (o_resync),
                .o_start_of_lane        (o_start_of_lane),
                .o_error_counter        (o_error_counter)
        );

endmodule

`default_nettype wire

// File: logic/am_matcher.sv
`timescale 1ns/10ps
`default_nettype none

module am_matcher
(
        input  wire                            i_clock,
        input  wire                            i_rst_n,
        input  wire am_code_pkg::coded_block_t i_data,
        input  wire                            i_valid,
        output am_lock_pkg::am_match_t         o_match
);
        import am_code_pkg::*;
        import am_lock_pkg::*;

        logic [N_ALIGNER-1:0]  lane_hit;
        logic                  hdr_ok;
        logic                  hit_d;
        logic [NB_LANE_ID-1:0] lane_d;
        logic                  hit_q;
        logic                  valid_q;
        logic [NB_LANE_ID-1:0] lane_q;
        coded_block_t          block_q;

        for (genvar k = 0; k < N_ALIGNER; k++)
        begin : g_lane
                assign lane_hit[k] = (i_data.m_low == am_lane_code[k]) &&
                                     (i_data.m_high == ~am_lane_code[k]);
        end

        assign hdr_ok = (i_data.sync_hdr == SYNC_CTRL);
        assign hit_d  = i_valid && hdr_ok && (|lane_hit);       // Idle cycles never hit

        // Table entries are distinct so at most one lane matches
        always_comb
        begin
                lane_d = '0;
                for (int k = 0; k < N_ALIGNER; k++)
                begin
                        if (lane_hit[k])
                        begin
                                lane_d = NB_LANE_ID'(k);
                        end
                end
        end

        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        hit_q   <= 1'b0;
                        valid_q <= 1'b0;
                end
                else
                begin
                        hit_q   <= hit_d;
                        valid_q <= i_valid;
                end
        end

        always_ff @(posedge i_clock)
        begin
                lane_q  <= lane_d;
                block_q <= i_data;
        end

        assign o_match = am_match_t'{
                hit:     hit_q,
                lane_id: lane_q,
                valid:   valid_q,
                block:   block_q
        };

endmodule

`default_nettype wire

// File: logic/am_period_counter.sv
`timescale 1ns/10ps
`default_nettype none

module am_period_counter
#(
        parameter int N_BLOCKS = 16
)
(
        input  wire                  i_clock,
        input  wire                  i_rst_n,
        input  wire                  i_valid,
        input  wire                  i_restart,
        output am_lock_pkg::period_t o_period
);
        import am_lock_pkg::*;

        localparam int NB_COUNT = (N_BLOCKS > 1) ? $clog2(N_BLOCKS) : 1;
        localparam logic [NB_COUNT-1:0] LAST_POS = NB_COUNT'(N_BLOCKS - 1);

        logic [NB_COUNT-1:0] cnt_q;                             // Position of last valid block
        logic [NB_COUNT-1:0] cnt_base;
        logic [NB_COUNT-1:0] cnt_next;
        period_t             period_q;

        // Restart makes the stage-1 block position 0
        assign cnt_base = i_restart ? '0 : cnt_q;
        assign cnt_next = (cnt_base == LAST_POS) ? '0 : cnt_base + 1'b1;

        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        cnt_q             <= '0;
                        period_q.expected <= 1'b0;
                end
                else if (i_valid)
                begin
                        cnt_q             <= cnt_next;
                        period_q.expected <= (cnt_next == '0);
                end
                else
                begin
                        cnt_q             <= cnt_base;          // Idle cycles hold the phase
                        period_q.expected <= 1'b0;
                end
        end

        assign o_period = period_q;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wall \
        --top-module tb_am_lock_top \
        -f am_lock_top.f \
        -o tb_am_lock_top

# Simulation exit status is not trusted, the log decides
./obj_dir/tb_am_lock_top > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
        exit 1
fi
if ! grep -q "TEST OK" sim.log; then
        exit 1
fi
exit 0

// File: sim/tb_am_lock_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_am_lock_top;
        import am_code_pkg::*;

        localparam int N_BLOCKS = 16;
        localparam int NB_ERR   = 64;

        logic                  tb_clock = 1'b0;
        logic                  i_rst_n = 1'b0;
        logic                  i_rf_enable = 1'b1;
        logic                  i_valid = 1'b0;
        logic                  i_block_lock = 1'b1;
        coded_block_t          i_data = '0;
        logic [4:0]            i_rf_valid_am_thr = 5'd5;
        logic [3:0]            i_rf_invalid_am_thr = 4'd3;
        coded_block_t          o_data;
        logic                  o_valid;
        logic [NB_LANE_ID-1:0] o_lane_id;
        logic [NB_ERR-1:0]     o_error_counter;
        logic                  o_am_lock;
        logic                  o_resync;
        logic                  o_start_of_lane;

        // Model state for stage 1 and stage 2
        logic                  m1_hit;
        logic                  m1_valid;
        logic                  m1_exp;
        int                    m1_lane;
        int                    pos;
        int                    st;
        int                    m_lane;
        int                    val_cnt;
        int                    inv_cnt;
        coded_block_t          m1_block;
        coded_block_t          e_data;
        logic                  e_valid;
        logic                  e_lock;
        logic                  e_resync;
        logic                  e_sol;
        int                    e_lane;
        logic [NB_ERR-1:0]     e_err;
        logic                  check_en = 1'b0;
        int                    resync_cnt = 0;
        int                    sol_cnt = 0;
        int                    lane;
        logic [NB_ERR-1:0]     err0;

        always #10 tb_clock = ~tb_clock;

        am_lock_top #(.N_BLOCKS(N_BLOCKS), .NB_ERROR_COUNTER(NB_ERR)) u_am_lock_top
        (
                .i_clock(tb_clock), .i_rst_n(i_rst_n), .i_rf_enable(i_rf_enable),
                .i_valid(i_valid), .i_block_lock(i_block_lock), .i_data(i_data),
                .i_rf_valid_am_thr(i_rf_valid_am_thr),
                .i_rf_invalid_am_thr(i_rf_invalid_am_thr),
                .o_data(o_data), .o_valid(o_valid), .o_lane_id(o_lane_id),
                .o_error_counter(o_error_counter), .o_am_lock(o_am_lock),
                .o_resync(o_resync), .o_start_of_lane(o_start_of_lane)
        );

        task automatic check_value(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
                if (expected !== actual)
                begin
                        $display("mismatch at %0t: %s expected %0h actual %0h",
                                 $time, name, expected, actual);
                        $display("TEST FAILED");
                        $fatal(1);
                end
        endtask

        // Reference model steps once per rising edge
        always @(posedge tb_clock)
        begin
                logic enabled;
                logic same;
                logic restart;
                enabled = i_rf_enable && i_block_lock;
                same    = m1_hit && (m1_lane == m_lane);
                restart = enabled && (st == 0) && m1_hit;
                e_resync = 1'b0;
                e_sol    = 1'b0;
                if (!i_rst_n)
                begin
                        st       = 0;
                        m_lane   = 0;
                        val_cnt  = 0;
                        inv_cnt  = 0;
                        e_err    = '0;
                        pos      = 0;
                        m1_exp   = 1'b0;
                        m1_hit   = 1'b0;
                        m1_valid = 1'b0;
                        e_valid  = 1'b0;
                end
                else
                begin
                        if (!enabled)
                        begin
                                st      = 0;
                                val_cnt = 0;
                                inv_cnt = 0;
                        end
                        else if (st == 0 && m1_hit)
                        begin
                                m_lane  = m1_lane;
                                val_cnt = 1;
                                inv_cnt = 0;
                                st      = (i_rf_valid_am_thr <= 1) ? 2 : 1;
                        end
                        else if (st == 1 && m1_exp)
                        begin
                                val_cnt = same ? val_cnt + 1 : 0;
                                st = !same ? 0 : (val_cnt >= i_rf_valid_am_thr) ? 2 : 1;
                        end
                        else if (st == 2 && m1_exp && same)
                        begin
                                inv_cnt = 0;
                                e_sol   = 1'b1;
                        end
                        else if (st == 2 && m1_exp)
                        begin
                                inv_cnt++;
                                e_err++;
                                if (inv_cnt >= i_rf_invalid_am_thr)
                                begin
                                        e_resync = 1'b1;
                                        st       = 0;
                                        val_cnt  = 0;
                                        inv_cnt  = 0;
                                end
                        end
                        e_valid = m1_valid;
                        pos = restart ? 0 : pos;
                        if (i_valid)
                                pos = (pos + 1) % N_BLOCKS;
                        m1_exp = i_valid && (pos == 0);
                        m1_hit = 1'b0;
                        for (int k = 0; k < N_ALIGNER; k++)
                        begin
                                if (i_valid && i_data.sync_hdr == 2'b10 &&
                                    i_data.m_low == am_lane_code[k] &&
                                    i_data.m_high == ~am_lane_code[k])
                                begin
                                        m1_hit  = 1'b1;
                                        m1_lane = k;
                                end
                        end
                        m1_valid = i_valid;
                end
                e_data   = m1_block;
                m1_block = i_data;
                e_lock   = (st == 2);
                e_lane   = m_lane;
        end

        always @(negedge tb_clock)
        begin
                if (check_en)
                begin
                        check_value("o_data", e_data, o_data);
                        check_value("o_valid", e_valid, o_valid);
                        check_value("o_am_lock", e_lock, o_am_lock);
                        check_value("o_lane_id", e_lane, o_lane_id);
                        check_value("o_resync", e_resync, o_resync);
                        check_value("o_start_of_lane", e_sol, o_start_of_lane);
                        check_value("o_error_counter", e_err, o_error_counter);
                        resync_cnt += o_resync;
                        sol_cnt    += o_start_of_lane;
                end
        end

        task automatic drive(input coded_block_t blk, input logic vld);
                @(posedge tb_clock);
                #1;
                i_data  = blk;
                i_valid = vld;
        endtask

        function automatic coded_block_t random_data();
                return {2'b01, $urandom, $urandom};
        endfunction

        function automatic coded_block_t marker_block(input int ln);
                return {SYNC_CTRL, am_lane_code[ln], 8'($urandom), ~am_lane_code[ln],
                        8'($urandom)};
        endfunction

        task automatic drive_valid(input coded_block_t blk);
                // Idle cycles carry markers of random lanes that must never hit
                while ($urandom % 8 == 0)
                        drive(marker_block($urandom % N_ALIGNER), 1'b0);
                drive(blk, 1'b1);
        endtask

        // One marker period with the marker first and data blocks after it
        task automatic send_period(input int ln, input logic corrupt);
                coded_block_t mk;
                int           bit_idx;
                mk = marker_block(ln);
                if (corrupt)
                begin
                        bit_idx = $urandom % NB_AM_CODE;
                        mk.m_low[bit_idx] = ~mk.m_low[bit_idx];
                end
                drive_valid(mk);
                for (int i = 1; i < N_BLOCKS; i++)
                        drive_valid(random_data());
        endtask

        task automatic wait_lock(input int ln, input int max_periods);
                int n;
                n = 0;
                while (!o_am_lock)
                begin
                        if (n == max_periods)
                        begin
                                $display("Timeout, lock was never reached");
                                $display("TEST FAILED");
                                $fatal(1);
                        end
                        send_period(ln, 1'b0);
                        n++;
                end
        endtask

        initial
        begin
                lane = $urandom(32'heec3d5ae) % N_ALIGNER;
                repeat (4) @(posedge tb_clock);
                #1 i_rst_n = 1'b1;
                repeat (3) drive(random_data(), 1'b1);
                check_en = 1'b1;
                wait_lock(lane, 20);
                check_value("o_lane_id", lane, o_lane_id);
                repeat (3) send_period(lane, 1'b0);
                err0 = e_err;
                repeat (2) send_period(lane, 1'b1);
                send_period(lane, 1'b0);
                check_value("error count step", err0 + 2, o_error_counter);
                check_value("lock kept", 1, o_am_lock);
                resync_cnt = 0;
                repeat (3) send_period(lane, 1'b1);
                check_value("resync pulses", 1, resync_cnt);
                check_value("lock dropped", 0, o_am_lock);
                lane = (lane + 1 + $urandom % (N_ALIGNER - 1)) % N_ALIGNER;
                wait_lock(lane, 20);
                check_value("new lane", lane, o_lane_id);
                resync_cnt = 0;
                i_block_lock = 1'b0;
                send_period(lane, 1'b0);
                check_value("lock after block lock drop", 0, o_am_lock);
                i_block_lock = 1'b1;
                wait_lock(lane, 20);
                i_rf_enable = 1'b0;
                send_period(lane, 1'b0);
                check_value("lock after disable", 0, o_am_lock);
                check_value("forced drop resync", 0, resync_cnt);
                i_rf_enable = 1'b1;
                wait_lock(lane, 20);
                sol_cnt = 0;
                repeat (4) send_period(lane, 1'b0);
                check_value("start of lane pulses", 4, sol_cnt);
                check_value("lock held over idles", 1, o_am_lock);
                repeat (3) drive(random_data(), 1'b1);
                $display("TEST OK");
                $finish;
        end

endmodule

`default_nettype wire
